//--- tb.f
+incdir+src
src/core_pkg.sv
src/de_ex_if.sv
src/instr_decoder.sv
src/de_ex.sv
src/scalar_execute.sv
src/core_top.sv
test/tb_clock.sv
test/core_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds core_tb with Verilator, runs it and looks for the pass line in the log.
verilator --binary --timing --assert -f tb.f --top-module core_tb -o core_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi
./obj_dir/core_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
exit 1

//--- test/core_tb.sv
`include "core_defines.svh"

module core_tb;
    import core_pkg::*;

    logic                       clk;
    logic                       rst = 1'b1;
    logic                       stall = 1'b0;
    logic [`INSTR_WIDTH-1:0]    instr = '0;
    logic [`PC_WIDTH-1:0]       instr_pc = '0;
    logic                       wb_en;
    logic [`REG_ADDR_WIDTH-1:0] wb_reg;
    logic [`DATA_WIDTH-1:0]     wb_data;
    logic                       redirect;
    logic [`PC_WIDTH-1:0]       redirect_pc;

    logic [`INSTR_WIDTH-1:0]    prog [64];
    logic [`DATA_WIDTH-1:0]     shadow [32] = '{default: '0};  // expected register file.
    logic [`PC_WIDTH-1:0]       pc = '0;
    int                         prog_len = 0;
    integer                     seed = 12;
    int                         errors = 0;
    int                         cycles = 0;
    logic                       exp_wb_en = 1'b0;
    logic [`REG_ADDR_WIDTH-1:0] exp_wb_reg = '0;
    logic [`DATA_WIDTH-1:0]     exp_wb_data = '0;
    logic                       exp_redirect = 1'b0;
    logic [`PC_WIDTH-1:0]       exp_redirect_pc = '0;
    logic                       last_stalled = 1'b0;

    tb_clock clock_gen (.clk(clk));

    core_top dut (.*);

    task automatic add_instr(input logic [3:0] op, input logic [3:0] fn,
                             input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [13:0] low);
        prog[prog_len[5:0]] = {op, fn, rd, rs1, low};
        prog_len++;
    endtask

    task automatic record_failure(input string msg);
        errors++;
        $display("FAILED at time %0t: %s", $time, msg);
    endtask

    // ************************************************************
    // expected behavior of execute for one accepted instruction
    // ************************************************************
    task automatic predict(input logic [`INSTR_WIDTH-1:0] ins,
                           input logic [`PC_WIDTH-1:0]    ipc);
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        logic [`DATA_WIDTH-1:0] c;
        logic [`DATA_WIDTH-1:0] simm;
        simm = {{18{ins[13]}}, ins[13:0]};
        a    = shadow[ins[18:14]];
        c    = shadow[ins[23:19]];  // a branch compares rs1 with the register in the rd field.
        b    = (ins[31:28] == OP_ALU) ? shadow[ins[13:9]] : simm;
        exp_wb_reg      = ins[23:19];
        exp_wb_en       = (ins[23:19] != 5'd0) &&
                          (ins[31:28] inside {OP_ALU, OP_ALUI, OP_LUI, OP_JUMP});
        exp_redirect    = 1'b0;
        exp_redirect_pc = ipc + {{22{ins[13]}}, ins[13:0]};
        case (ins[27:24])
            ALU_ADD: exp_wb_data = a + b;
            ALU_SUB: exp_wb_data = a - b;
            ALU_AND: exp_wb_data = a & b;
            ALU_OR:  exp_wb_data = a | b;
            ALU_XOR: exp_wb_data = a ^ b;
            ALU_SLL: exp_wb_data = a << b[4:0];
            ALU_SRL: exp_wb_data = a >> b[4:0];
            ALU_SLT: exp_wb_data = {31'd0, ($signed(a) < $signed(b))};
            default: exp_wb_data = '0;
        endcase
        case (ins[31:28])
            OP_LUI: exp_wb_data = simm;
            OP_JUMP: begin
                exp_wb_data  = ipc[`DATA_WIDTH-1:0] + 32'd1;
                exp_redirect = 1'b1;
            end
            OP_BRANCH: begin
                exp_redirect = (ins[26:24] == BR_EQ) ? (a == c) :
                               (ins[26:24] == BR_NE) ? (a != c) :
                               (ins[26:24] == BR_LT) && ($signed(a) < $signed(c));
            end
            default: ;
        endcase
    endtask

    task automatic build_program();
        logic [31:0] rnd;
        for (int i = 1; i <= 4; i++) begin
            rnd = $random(seed);
            add_instr(OP_LUI, 4'd0, 5'(i), 5'd0, rnd[13:0]);  // random operands in r1 to r4.
        end
        for (int k = 0; k < 8; k++) begin
            rnd = $random(seed);
            add_instr(OP_ALU, 4'(k), 5'(5 + k), 5'd1, {5'd2, 9'd0});
            add_instr(OP_ALUI, 4'(k), 5'(13 + k), 5'd3, rnd[13:0]);
        end
        add_instr(OP_ALU, ALU_ADD, 5'd0, 5'd1, {5'd2, 9'd0});
        add_instr(OP_ALU, ALU_OR, 5'd21, 5'd0, {5'd4, 9'd0});
        add_instr(OP_ALUI, ALU_ADD, 5'd22, 5'd1, 14'd5);
        add_instr(OP_ALU, ALU_SUB, 5'd23, 5'd22, {5'd4, 9'd0});  // needs r22 from just before.
        add_instr(OP_LUI, 4'd0, 5'd24, 5'd0, 14'd7);
        add_instr(OP_LUI, 4'd0, 5'd25, 5'd0, 14'd7);
        add_instr(OP_LUI, 4'd0, 5'd26, 5'd0, 14'h3ffd);
        add_instr(OP_BRANCH, 4'(BR_EQ), 5'd25, 5'd24, 14'd2);
        add_instr(OP_LUI, 4'd0, 5'd27, 5'd0, 14'd99);
        add_instr(OP_BRANCH, 4'(BR_NE), 5'd25, 5'd24, 14'd2);
        add_instr(OP_BRANCH, 4'(BR_NE), 5'd26, 5'd24, 14'd2);
        add_instr(OP_LUI, 4'd0, 5'd28, 5'd0, 14'd55);
        add_instr(OP_BRANCH, 4'(BR_LT), 5'd24, 5'd26, 14'd2);  // -3 < 7, so taken.
        add_instr(OP_LUI, 4'd0, 5'd27, 5'd0, 14'd42);
        add_instr(OP_BRANCH, 4'(BR_LT), 5'd26, 5'd24, 14'd2);
        add_instr(OP_BRANCH, 4'(BR_EQ), 5'd26, 5'd25, 14'd2);
        add_instr(OP_JUMP, 4'd0, 5'd29, 5'd0, 14'd2);
        add_instr(OP_LUI, 4'd0, 5'd28, 5'd0, 14'd77);
        add_instr(OP_ALU, ALU_OR, 5'd30, 5'd27, {5'd28, 9'd0});  // dropped writes read as zero.
    endtask

    // ************************************************************
    // program counter model and stimulus
    // ************************************************************
    always @(posedge clk) begin : pc_model
        logic [`PC_WIDTH-1:0] next_pc;
        logic [31:0]          roll;
        next_pc = pc;
        if (!rst) begin
            if (exp_wb_en) begin
                shadow[exp_wb_reg] = exp_wb_data;  // the DUT writes its register file now.
            end
            last_stalled = stall;
            if (redirect || stall) begin
                exp_wb_en    = 1'b0;
                exp_redirect = 1'b0;
            end else begin
                predict(instr, instr_pc);
                next_pc = pc + 36'd1;
            end
            if (redirect) begin
                next_pc = redirect_pc;
            end
        end
        pc       = next_pc;
        roll     = $random(seed);
        instr    <= (pc < 36'(prog_len)) ? prog[pc[5:0]] : '0;
        instr_pc <= pc;
        stall    <= !rst && (roll[1:0] == 2'b00);
    end

    assert property (@(posedge clk) disable iff (rst) wb_en == exp_wb_en &&
                     (!exp_wb_en || (wb_reg == exp_wb_reg && wb_data == exp_wb_data)))
        else record_failure("writeback differs from the model");
    assert property (@(posedge clk) disable iff (rst) redirect == exp_redirect &&
                     (!exp_redirect || redirect_pc == exp_redirect_pc))
        else record_failure("redirect differs from the model");
    assert property (@(posedge clk) disable iff (rst) !(last_stalled && wb_en))
        else record_failure("writeback in the cycle after a stalled edge");

    initial begin
        build_program();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        while (pc < 36'(prog_len) && cycles < 4 * prog_len + 50) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= 4 * prog_len + 50) begin
            $display("timeout: the program did not finish within %0d cycles", cycles);
            errors++;
        end
        repeat (4) @(negedge clk);
        $display("ran %0d cycles, %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- test/tb_clock.sv
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // period of 100 time units.
    end

endmodule

//--- src/core_top.sv
`include "core_defines.svh"

module core_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,
    input  logic [`INSTR_WIDTH-1:0]    instr,
    input  logic [`PC_WIDTH-1:0]       instr_pc,
    output logic                       wb_en,
    output logic [`REG_ADDR_WIDTH-1:0] wb_reg,
    output logic [`DATA_WIDTH-1:0]     wb_data,
    output logic                       redirect,
    output logic [`PC_WIDTH-1:0]       redirect_pc
);

    de_ex_if dec_bus ();
    de_ex_if ex_bus ();

    instr_decoder u_instr_decoder (
        .instr    (instr),
        .instr_pc (instr_pc),
        .dec      (dec_bus)
    );

    de_ex u_de_ex (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .flush (redirect),      // a taken branch or jump drops the instruction at decode.
        .dec   (dec_bus),
        .ex    (ex_bus)
    );

    scalar_execute u_scalar_execute (
        .clk         (clk),
        .rst         (rst),
        .ex          (ex_bus),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

//--- src/scalar_execute.sv
`include "core_defines.svh"

module scalar_execute (
    input  logic                       clk,
    input  logic                       rst,
    de_ex_if.dst                       ex,
    output logic                       wb_en,
    output logic [`REG_ADDR_WIDTH-1:0] wb_reg,
    output logic [`DATA_WIDTH-1:0]     wb_data,
    output logic                       redirect,
    output logic [`PC_WIDTH-1:0]       redirect_pc
);
    import core_pkg::*;

    localparam int NUM_REGS = 2 ** `REG_ADDR_WIDTH;

    logic [`DATA_WIDTH-1:0] regs [NUM_REGS];
    logic [`DATA_WIDTH-1:0] rs1_val;
    logic [`DATA_WIDTH-1:0] rs2_val;
    logic [`DATA_WIDTH-1:0] imm_data;
    logic [`PC_WIDTH-1:0]   imm_pc;
    logic [`DATA_WIDTH-1:0] op_b;
    logic [`DATA_WIDTH-1:0] alu_result;
    logic                   taken;

    // ************************************************************
    // operand read and select
    // ************************************************************
    assign rs1_val  = (ex.scalar_read_register1 == '0) ? '0 : regs[ex.scalar_read_register1];
    assign rs2_val  = (ex.scalar_read_register2 == '0) ? '0 : regs[ex.scalar_read_register2];
    assign imm_data = {{(`DATA_WIDTH - `IMM_WIDTH){ex.imm[`IMM_WIDTH-1]}}, ex.imm};
    assign imm_pc   = {{(`PC_WIDTH - `IMM_WIDTH){ex.imm[`IMM_WIDTH-1]}}, ex.imm};
    assign op_b     = ex.alu_operands ? imm_data : rs2_val;

    always_comb begin
        case (ex.scalar_alu_op)
            ALU_ADD: alu_result = rs1_val + op_b;
            ALU_SUB: alu_result = rs1_val - op_b;
            ALU_AND: alu_result = rs1_val & op_b;
            ALU_OR:  alu_result = rs1_val | op_b;
            ALU_XOR: alu_result = rs1_val ^ op_b;
            ALU_SLL: alu_result = rs1_val << op_b[4:0];
            ALU_SRL: alu_result = rs1_val >> op_b[4:0];
            ALU_SLT: alu_result = {{(`DATA_WIDTH - 1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
            default: alu_result = '0;
        endcase
    end

    always_comb begin
        case (ex.branch_control)
            BR_EQ:   taken = (rs1_val == rs2_val);
            BR_NE:   taken = (rs1_val != rs2_val);
            BR_LT:   taken = ($signed(rs1_val) < $signed(rs2_val));
            default: taken = 1'b0;
        endcase
    end

    // ************************************************************
    // writeback and redirect
    // ************************************************************
    assign wb_en   = ex.valid & ex.register_wr_en;
    assign wb_reg  = ex.scalar_write_register;
    assign wb_data = ex.store_pc              ? ex.pc[`DATA_WIDTH-1:0] + 1'b1 :
                     (ex.op_type == OP_LUI)   ? imm_data : alu_result;

    assign redirect    = ex.valid & ((ex.op_type == OP_JUMP) |
                                     ((ex.op_type == OP_BRANCH) & taken));
    assign redirect_pc = ex.pc + imm_pc;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_reg] <= wb_data;  // seen by the next accepted instruction.
        end
    end

endmodule

//--- src/de_ex.sv
`include "core_defines.svh"

module de_ex (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic flush,
    de_ex_if.dst dec,
    de_ex_if.src ex
);
    import core_pkg::*;

    logic bubble;

    assign bubble = flush | stall;  // either one keeps the offered instruction out.

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ex.valid                 <= 1'b0;
            ex.pc                    <= '0;
            ex.op_type               <= OP_NOP;
            ex.scalar_alu_op         <= ALU_ADD;
            ex.branch_control        <= BR_EQ;
            ex.scalar_read_register1 <= '0;
            ex.scalar_read_register2 <= '0;
            ex.scalar_write_register <= '0;
            ex.register_wr_en        <= 1'b0;
            ex.alu_operands          <= 1'b0;
            ex.store_pc              <= 1'b0;
            ex.imm                   <= '0;
        end else if (bubble) begin
            ex.valid          <= 1'b0;  // the data fields keep their old value.
            ex.register_wr_en <= 1'b0;
            ex.op_type        <= OP_NOP;
        end else begin
            ex.valid                 <= dec.valid;
            ex.pc                    <= dec.pc;
            ex.op_type               <= dec.op_type;
            ex.scalar_alu_op         <= dec.scalar_alu_op;
            ex.branch_control        <= dec.branch_control;
            ex.scalar_read_register1 <= dec.scalar_read_register1;
            ex.scalar_read_register2 <= dec.scalar_read_register2;
            ex.scalar_write_register <= dec.scalar_write_register;
            ex.register_wr_en        <= dec.register_wr_en;
            ex.alu_operands          <= dec.alu_operands;
            ex.store_pc              <= dec.store_pc;
            ex.imm                   <= dec.imm;
        end
    end

endmodule

//--- src/instr_decoder.sv
`include "core_defines.svh"

module instr_decoder (
    input  logic [`INSTR_WIDTH-1:0] instr,
    input  logic [`PC_WIDTH-1:0]    instr_pc,
    de_ex_if.src                    dec
);
    import core_pkg::*;

    logic [3:0]                 opcode;
    logic [3:0]                 funct;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic                       rd_nonzero;

    assign opcode     = instr[`OPCODE_MSB:`OPCODE_LSB];
    assign funct      = instr[`FUNCT_MSB:`FUNCT_LSB];
    assign rd         = instr[`RD_MSB:`RD_LSB];
    assign rs1        = instr[`RS1_MSB:`RS1_LSB];
    assign rs2        = instr[`RS2_MSB:`RS2_LSB];
    assign rd_nonzero = (rd != '0);

    always_comb begin
        dec.pc                    = instr_pc;
        dec.imm                   = instr[`IMM_MSB:`IMM_LSB];
        dec.scalar_alu_op         = scalar_alu_op_e'(funct);
        dec.branch_control        = branch_control_e'(funct[2:0]);
        dec.scalar_read_register1 = rs1;
        dec.scalar_read_register2 = rs2;
        dec.scalar_write_register = rd;
        dec.valid                 = 1'b1;
        dec.op_type               = OP_NOP;
        dec.register_wr_en        = 1'b0;
        dec.alu_operands          = 1'b0;
        dec.store_pc              = 1'b0;

        case (opcode)
            OP_NOP: begin
                dec.op_type = OP_NOP;
            end
            OP_ALU: begin
                dec.op_type        = OP_ALU;
                dec.register_wr_en = rd_nonzero;
            end
            OP_ALUI: begin
                dec.op_type        = OP_ALUI;
                dec.register_wr_en = rd_nonzero;
                dec.alu_operands   = 1'b1;
            end
            OP_LUI: begin
                dec.op_type        = OP_LUI;
                dec.register_wr_en = rd_nonzero;
                dec.alu_operands   = 1'b1;
            end
            OP_BRANCH: begin
                // the immediate holds the offset, so the second compare
                // register comes from the rd field, which a branch does not write.
                dec.op_type               = OP_BRANCH;
                dec.scalar_read_register2 = rd;
            end
            OP_JUMP: begin
                dec.op_type        = OP_JUMP;
                dec.register_wr_en = rd_nonzero;  // link register.
                dec.store_pc       = 1'b1;
            end
            default: begin
                dec.valid = 1'b0;                 // unknown opcode becomes a bubble.
            end
        endcase
    end

endmodule

//--- src/de_ex_if.sv
`include "core_defines.svh"

interface de_ex_if;
    import core_pkg::*;

    logic                       valid;
    logic [`PC_WIDTH-1:0]       pc;
    op_type_e                   op_type;
    scalar_alu_op_e             scalar_alu_op;
    branch_control_e            branch_control;
    logic [`REG_ADDR_WIDTH-1:0] scalar_read_register1;
    logic [`REG_ADDR_WIDTH-1:0] scalar_read_register2;
    logic [`REG_ADDR_WIDTH-1:0] scalar_write_register;
    logic                       register_wr_en;
    logic                       alu_operands;   // immediate replaces the second operand.
    logic                       store_pc;       // writes pc+1 as the link value.
    logic [`IMM_WIDTH-1:0]      imm;

    modport src (
        output valid, pc, op_type, scalar_alu_op, branch_control,
        output scalar_read_register1, scalar_read_register2, scalar_write_register,
        output register_wr_en, alu_operands, store_pc, imm
    );

    modport dst (
        input valid, pc, op_type, scalar_alu_op, branch_control,
        input scalar_read_register1, scalar_read_register2, scalar_write_register,
        input register_wr_en, alu_operands, store_pc, imm
    );

endinterface

//--- src/core_pkg.sv
package core_pkg;

    // ************************************************************
    // opcode in the top nibble of the instruction
    // ************************************************************
    typedef enum logic [3:0] {
        OP_NOP    = 4'h0,
        OP_ALU    = 4'h1,     // register-register form.
        OP_ALUI   = 4'h2,     // register-immediate form.
        OP_LUI    = 4'h3,     // loads the sign-extended immediate.
        OP_BRANCH = 4'h4,
        OP_JUMP   = 4'h5
    } op_type_e;

    // ************************************************************
    // scalar alu operation in the function field
    // ************************************************************
    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_AND = 4'h2,
        ALU_OR  = 4'h3,
        ALU_XOR = 4'h4,
        ALU_SLL = 4'h5,
        ALU_SRL = 4'h6,
        ALU_SLT = 4'h7        // signed compare giving 1 or 0.
    } scalar_alu_op_e;

    // ************************************************************
    // branch condition in the low three bits of the function field
    // ************************************************************
    typedef enum logic [2:0] {
        BR_EQ = 3'h0,
        BR_NE = 3'h1,
        BR_LT = 3'h2          // signed less-than.
    } branch_control_e;

endpackage

//--- src/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// ************************************************************
// datapath widths
// ************************************************************
`define PC_WIDTH        36
`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5
`define INSTR_WIDTH     32
`define IMM_WIDTH       14

// ************************************************************
// instruction field positions
// ************************************************************
`define OPCODE_MSB      31
`define OPCODE_LSB      28
`define FUNCT_MSB       27
`define FUNCT_LSB       24
`define RD_MSB          23
`define RD_LSB          19
`define RS1_MSB         18
`define RS1_LSB         14
`define RS2_MSB         13
`define RS2_LSB         9
`define IMM_MSB         13
`define IMM_LSB         0

`endif
